// ==== flist.f ====
hw/ahbApbPkg.sv
hw/periphPkg.sv
hw/apbIf.sv
hw/ahbApbBridge.sv
hw/apbInterconnect.sv
hw/timerPeripheral.sv
hw/pwmPeripheral.sv
hw/apbSubsystem.sv
verification/apbSubsystemChecker.sv
verification/tbApbSubsystem.sv

// ==== hw/ahbApbBridge.sv ====
module ahbApbBridge (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  ahbApbPkg::addrT   hAddr_i,
    input  ahbApbPkg::htransE hTrans_i,
    input  logic              hWrite_i,
    input  ahbApbPkg::dataT   hWData_i,
    input  logic              hSel_i,
    input  logic              hReady_i,
    output ahbApbPkg::dataT   hRData_o,
    output logic              hReadyOut_o,
    apbIf.master              apbM
);

    ahbApbPkg::bridgeStateE state;
    ahbApbPkg::bridgeStateE nextState;
    ahbApbPkg::addrT        addrReg;
    logic                   writeReg;
    ahbApbPkg::dataT        wDataReg;
    logic                   start;

    // Only NONSEQ and SEQ open a transfer, and only while the bridge is free
    assign start = hSel_i && hReady_i && hReadyOut_o &&
                   ((hTrans_i == ahbApbPkg::HTRANS_NONSEQ) ||
                    (hTrans_i == ahbApbPkg::HTRANS_SEQ));

    assign hReadyOut_o = (state == ahbApbPkg::ST_IDLE) || (state == ahbApbPkg::ST_DONE);

    always_comb begin
        nextState = state;
        case (state)
            ahbApbPkg::ST_IDLE,
            ahbApbPkg::ST_DONE: begin
                if (start) begin
                    nextState = ahbApbPkg::ST_SETUP;
                end else begin
                    nextState = ahbApbPkg::ST_IDLE;
                end
            end
            ahbApbPkg::ST_SETUP: nextState = ahbApbPkg::ST_ACCESS;
            // Stays in access under back-pressure
            ahbApbPkg::ST_ACCESS: begin
                if (apbM.pReady) begin
                    nextState = ahbApbPkg::ST_DONE;
                end
            end
            default: nextState = ahbApbPkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state <= ahbApbPkg::ST_IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Address phase, write data phase and read data capture
    always_ff @(posedge HCLK) begin
        if (start) begin
            addrReg  <= hAddr_i;
            writeReg <= hWrite_i;
        end
        if (state == ahbApbPkg::ST_SETUP) begin
            wDataReg <= hWData_i;
        end
        if ((state == ahbApbPkg::ST_ACCESS) && apbM.pReady) begin
            hRData_o <= apbM.pRData;
        end
    end

    assign apbM.pAddr   = addrReg;
    assign apbM.pWrite  = writeReg;
    // Write data comes straight from HWDATA in setup, from the register after
    assign apbM.pWData  = (state == ahbApbPkg::ST_SETUP) ? hWData_i : wDataReg;
    assign apbM.pSel    = (state == ahbApbPkg::ST_SETUP) || (state == ahbApbPkg::ST_ACCESS);
    assign apbM.pEnable = (state == ahbApbPkg::ST_ACCESS);

endmodule

// ==== hw/ahbApbPkg.sv ====
package ahbApbPkg;

    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addrT;
    typedef logic [DATA_WIDTH-1:0] dataT;

    // Peripheral slot field in PADDR
    localparam int SLOT_MSB = 23;
    localparam int SLOT_LSB = 20;

    // Word offset of a register inside a peripheral
    localparam int OFFSET_MSB = 4;
    localparam int OFFSET_LSB = 2;

    // Slot map
    localparam logic [SLOT_MSB-SLOT_LSB:0] TIMER_SLOT = 4'd0;
    localparam logic [SLOT_MSB-SLOT_LSB:0] PWM_SLOT = 4'd1;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htransE;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_DONE
    } bridgeStateE;

endpackage

// ==== hw/apbIf.sv ====
interface apbIf;

    ahbApbPkg::addrT pAddr;
    logic            pWrite;
    ahbApbPkg::dataT pWData;
    logic            pEnable;
    logic            pSel;
    ahbApbPkg::dataT pRData;
    logic            pReady;

    modport master (
        output pAddr,
        output pWrite,
        output pWData,
        output pEnable,
        output pSel,
        input  pRData,
        input  pReady
    );

    modport slave (
        input  pAddr,
        input  pWrite,
        input  pWData,
        input  pEnable,
        input  pSel,
        output pRData,
        output pReady
    );

endinterface

// ==== hw/apbInterconnect.sv ====
module apbInterconnect (
    apbIf.slave  apbS,
    apbIf.master timerM,
    apbIf.master pwmM
);

    logic [ahbApbPkg::SLOT_MSB-ahbApbPkg::SLOT_LSB:0] slot;
    logic timerHit;
    logic pwmHit;

    assign slot     = apbS.pAddr[ahbApbPkg::SLOT_MSB:ahbApbPkg::SLOT_LSB];
    assign timerHit = (slot == ahbApbPkg::TIMER_SLOT);
    assign pwmHit   = (slot == ahbApbPkg::PWM_SLOT);

    // Shared request lines
    assign timerM.pAddr   = apbS.pAddr;
    assign timerM.pWrite  = apbS.pWrite;
    assign timerM.pWData  = apbS.pWData;
    assign timerM.pEnable = apbS.pEnable;
    assign pwmM.pAddr     = apbS.pAddr;
    assign pwmM.pWrite    = apbS.pWrite;
    assign pwmM.pWData    = apbS.pWData;
    assign pwmM.pEnable   = apbS.pEnable;

    // Select only on the decoded slot
    assign timerM.pSel = apbS.pSel && timerHit;
    assign pwmM.pSel   = apbS.pSel && pwmHit;

    always_comb begin
        if (timerHit) begin
            apbS.pRData = timerM.pRData;
            apbS.pReady = timerM.pReady;
        end else if (pwmHit) begin
            apbS.pRData = pwmM.pRData;
            apbS.pReady = pwmM.pReady;
        end else begin
            // Unmapped slot reads zero, never stalls
            apbS.pRData = '0;
            apbS.pReady = 1'b1;
        end
    end

endmodule

// ==== hw/apbSubsystem.sv ====
module apbSubsystem (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  ahbApbPkg::addrT   hAddr_i,
    input  ahbApbPkg::htransE hTrans_i,
    input  logic              hWrite_i,
    input  ahbApbPkg::dataT   hWData_i,
    input  logic              hSel_i,
    input  logic              hReady_i,
    output ahbApbPkg::dataT   hRData_o,
    output logic              hReadyOut_o,
    output logic              pwm_o,
    output logic              timerIrq_o
);

    // Bridge side and one bus per peripheral
    apbIf busIf ();
    apbIf timerBus ();
    apbIf pwmBus ();

    ahbApbBridge bridge (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .hAddr_i     (hAddr_i),
        .hTrans_i    (hTrans_i),
        .hWrite_i    (hWrite_i),
        .hWData_i    (hWData_i),
        .hSel_i      (hSel_i),
        .hReady_i    (hReady_i),
        .hRData_o    (hRData_o),
        .hReadyOut_o (hReadyOut_o),
        .apbM        (busIf.master)
    );

    apbInterconnect apbBus (
        .apbS   (busIf.slave),
        .timerM (timerBus.master),
        .pwmM   (pwmBus.master)
    );

    timerPeripheral timer0 (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .apbS    (timerBus.slave),
        .irq_o   (timerIrq_o)
    );

    pwmPeripheral pwm0 (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .apbS    (pwmBus.slave),
        .pwm_o   (pwm_o)
    );

endmodule

// ==== hw/periphPkg.sv ====
package periphPkg;

    // Prescaler and counter width
    localparam int COUNT_WIDTH = 32;

    typedef logic [COUNT_WIDTH-1:0] countT;

    // Timer register map, word offsets
    typedef enum logic [2:0] {
        TIMER_TMR    = 3'd0,
        TIMER_PRE    = 3'd1,
        TIMER_CMP    = 3'd2,
        TIMER_STATUS = 3'd3,
        TIMER_CTRL   = 3'd4
    } timerRegE;

    // PWM register map, word offsets
    typedef enum logic [2:0] {
        PWM_PRE    = 3'd0,
        PWM_PERIOD = 3'd1,
        PWM_DUTY   = 3'd2,
        PWM_CTRL   = 3'd3
    } pwmRegE;

endpackage

// ==== hw/pwmPeripheral.sv ====
module pwmPeripheral (
    input  logic HCLK,
    input  logic HRESETn,
    apbIf.slave  apbS,
    output logic pwm_o
);

    periphPkg::countT  pre;
    periphPkg::countT  period;
    periphPkg::countT  duty;
    periphPkg::countT  preCnt;
    periphPkg::countT  perCnt;
    logic              enable;
    logic              wrEn;
    periphPkg::pwmRegE offset;

    assign offset = periphPkg::pwmRegE'(
                        apbS.pAddr[ahbApbPkg::OFFSET_MSB:ahbApbPkg::OFFSET_LSB]);
    assign wrEn   = apbS.pSel && apbS.pEnable && apbS.pWrite;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            pre    <= '0;
            period <= '0;
            duty   <= '0;
            enable <= 1'b0;
        end else if (wrEn) begin
            case (offset)
                periphPkg::PWM_PRE:    pre    <= apbS.pWData;
                periphPkg::PWM_PERIOD: period <= apbS.pWData;
                periphPkg::PWM_DUTY:   duty   <= apbS.pWData;
                periphPkg::PWM_CTRL:   enable <= apbS.pWData[0];
                default: begin
                end
            endcase
        end
    end

    // Period counter advances once per prescaler wrap
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preCnt <= '0;
            perCnt <= '0;
            pwm_o  <= 1'b0;
        end else if (!enable) begin
            preCnt <= '0;
            perCnt <= '0;
            pwm_o  <= 1'b0;
        end else begin
            pwm_o <= (perCnt < duty);
            if (preCnt == pre) begin
                preCnt <= '0;
                if (perCnt >= period) begin
                    perCnt <= '0;
                end else begin
                    perCnt <= perCnt + 1'b1;
                end
            end else begin
                preCnt <= preCnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (offset)
            periphPkg::PWM_PRE:    apbS.pRData = pre;
            periphPkg::PWM_PERIOD: apbS.pRData = period;
            periphPkg::PWM_DUTY:   apbS.pRData = duty;
            periphPkg::PWM_CTRL:   apbS.pRData = ahbApbPkg::dataT'(enable);
            default:               apbS.pRData = '0;
        endcase
    end

    assign apbS.pReady = 1'b1;

endmodule

// ==== hw/timerPeripheral.sv ====
module timerPeripheral (
    input  logic HCLK,
    input  logic HRESETn,
    apbIf.slave  apbS,
    output logic irq_o
);

    periphPkg::countT    tmr;
    periphPkg::countT    pre;
    periphPkg::countT    cmp;
    periphPkg::countT    preCnt;
    logic                enable;
    logic                ovFlag;
    logic                tick;
    logic                tmrWrap;
    logic                wrEn;
    periphPkg::timerRegE offset;

    assign offset  = periphPkg::timerRegE'(
                         apbS.pAddr[ahbApbPkg::OFFSET_MSB:ahbApbPkg::OFFSET_LSB]);
    assign wrEn    = apbS.pSel && apbS.pEnable && apbS.pWrite;
    assign tick    = enable && (preCnt == pre);
    assign tmrWrap = tick && (tmr >= cmp);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            pre    <= '0;
            cmp    <= '0;
            enable <= 1'b0;
        end else if (wrEn) begin
            case (offset)
                periphPkg::TIMER_PRE:  pre    <= apbS.pWData;
                periphPkg::TIMER_CMP:  cmp    <= apbS.pWData;
                periphPkg::TIMER_CTRL: enable <= apbS.pWData[0];
                default: begin
                end
            endcase
        end
    end

    // Prescaler and main counter, both restart when disabled
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preCnt <= '0;
            tmr    <= '0;
        end else if (!enable) begin
            preCnt <= '0;
            tmr    <= '0;
        end else if (tick) begin
            preCnt <= '0;
            if (tmrWrap) begin
                tmr <= '0;
            end else begin
                tmr <= tmr + 1'b1;
            end
        end else begin
            preCnt <= preCnt + 1'b1;
        end
    end

    // Overflow wins over a clear in the same cycle
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            ovFlag <= 1'b0;
        end else if (tmrWrap) begin
            ovFlag <= 1'b1;
        end else if (wrEn && (offset == periphPkg::TIMER_STATUS) && apbS.pWData[0]) begin
            ovFlag <= 1'b0;
        end
    end

    always_comb begin
        case (offset)
            periphPkg::TIMER_TMR:    apbS.pRData = tmr;
            periphPkg::TIMER_PRE:    apbS.pRData = pre;
            periphPkg::TIMER_CMP:    apbS.pRData = cmp;
            periphPkg::TIMER_STATUS: apbS.pRData = ahbApbPkg::dataT'(ovFlag);
            periphPkg::TIMER_CTRL:   apbS.pRData = ahbApbPkg::dataT'(enable);
            default:                 apbS.pRData = '0;
        endcase
    end

    assign apbS.pReady = 1'b1;
    assign irq_o       = ovFlag;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the simulation log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f flist.f --top-module tbApbSubsystem -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/apbSubsystemChecker.sv ====
module apbSubsystemChecker (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  ahbApbPkg::addrT   hAddr_i,
    input  ahbApbPkg::htransE hTrans_i,
    input  logic              hWrite_i,
    input  ahbApbPkg::dataT   hWData_i,
    input  logic              hSel_i,
    input  logic              hReady_i,
    input  ahbApbPkg::dataT   hRData_i,
    input  logic              hReadyOut_i,
    input  logic              pwm_i,
    input  logic              timerIrq_i,
    output int                dataErrors_o,
    output int                timingErrors_o,
    output int                periphErrors_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int              dataErrors = 0;
    int              timingErrors = 0;
    int              periphErrors = 0;
    int              phase;
    int              timerWait;
    int              sinceRise;
    logic            seenRise;
    logic            pwmPrev;
    logic            pwmEnPrev;
    logic            pwmEn;
    logic            accept;
    ahbApbPkg::addrT addrReg;
    logic            writeReg;
    ahbApbPkg::dataT wDataReg;
    ahbApbPkg::dataT expected;
    ahbApbPkg::dataT timerRegs [8];
    ahbApbPkg::dataT pwmRegs [8];
    logic [ahbApbPkg::SLOT_MSB-ahbApbPkg::SLOT_LSB:0]     slot;
    logic [ahbApbPkg::OFFSET_MSB-ahbApbPkg::OFFSET_LSB:0] offset;

    assign accept = hSel_i && hReady_i && hReadyOut_i &&
                    ((hTrans_i == ahbApbPkg::HTRANS_NONSEQ) ||
                     (hTrans_i == ahbApbPkg::HTRANS_SEQ));
    assign slot   = addrReg[ahbApbPkg::SLOT_MSB:ahbApbPkg::SLOT_LSB];
    assign offset = addrReg[ahbApbPkg::OFFSET_MSB:ahbApbPkg::OFFSET_LSB];
    assign pwmEn  = pwmRegs[periphPkg::PWM_CTRL][0];
    // Mapped registers read back what was written and other slots read zero
    assign expected = (slot == ahbApbPkg::TIMER_SLOT) ? timerRegs[offset] :
                      (slot == ahbApbPkg::PWM_SLOT) ? pwmRegs[offset] : '0;

    assign dataErrors_o   = dataErrors;
    assign timingErrors_o = timingErrors;
    assign periphErrors_o = periphErrors;

    always @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            phase     <= 0;
            timerWait <= 0;
            sinceRise <= 0;
            seenRise  <= 1'b0;
            pwmPrev   <= 1'b0;
            pwmEnPrev <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                timerRegs[i] <= '0;
                pwmRegs[i]   <= '0;
            end
        end else begin
            // Two wait states per transfer, ready otherwise
            if ((phase == 1) || (phase == 2)) begin
                assert (!hReadyOut_i) else begin
                    timingErrors++;
                    $display("ERROR hReadyOut_o: got 0x%h expected 0x0", hReadyOut_i);
                end
            end else begin
                assert (hReadyOut_i) else begin
                    timingErrors++;
                    $display("ERROR hReadyOut_o: got 0x%h expected 0x1", hReadyOut_i);
                end
            end
            if (phase == 1) begin
                wDataReg <= hWData_i;
            end
            if (timerWait > 0) begin
                assert (timerIrq_i || (timerWait != 1)) else begin
                    periphErrors++;
                    $display("Timer interrupt did not rise within the expected window");
                end
                timerWait <= timerIrq_i ? 0 : timerWait - 1;
            end
            if ((phase == 3) && !writeReg) begin
                if ((slot == ahbApbPkg::TIMER_SLOT) && (offset == periphPkg::TIMER_TMR)) begin
                    assert (hRData_i <= timerRegs[periphPkg::TIMER_CMP]) else begin
                        periphErrors++;
                        $display("ERROR hRData_o: TMR 0x%h above CMP 0x%h",
                                 hRData_i, timerRegs[periphPkg::TIMER_CMP]);
                    end
                end else if (!((slot == ahbApbPkg::TIMER_SLOT) &&
                               (offset == periphPkg::TIMER_STATUS))) begin
                    assert (hRData_i == expected) else begin
                        dataErrors++;
                        $display("ERROR hRData_o: got 0x%h expected 0x%h at 0x%h",
                                 hRData_i, expected, addrReg);
                    end
                end
            end
            if ((phase == 3) && writeReg && (slot == ahbApbPkg::TIMER_SLOT)) begin
                if ((offset == periphPkg::TIMER_PRE) || (offset == periphPkg::TIMER_CMP)) begin
                    timerRegs[offset] <= wDataReg;
                end
                if (offset == periphPkg::TIMER_CTRL) begin
                    timerRegs[offset] <= ahbApbPkg::dataT'(wDataReg[0]);
                    if (wDataReg[0]) begin
                        timerWait <= (timerRegs[periphPkg::TIMER_CMP] + 1) *
                                     (timerRegs[periphPkg::TIMER_PRE] + 1) + 4;
                    end
                end
                // Clearing is only meaningful once the counter is stopped
                if ((offset == periphPkg::TIMER_STATUS) && wDataReg[0] &&
                    !timerRegs[periphPkg::TIMER_CTRL][0]) begin
                    assert (!timerIrq_i) else begin
                        periphErrors++;
                        $display("ERROR timerIrq_o: got 0x%h expected 0x0", timerIrq_i);
                    end
                end
            end
            if ((phase == 3) && writeReg && (slot == ahbApbPkg::PWM_SLOT)) begin
                if (offset < periphPkg::PWM_CTRL) begin
                    pwmRegs[offset] <= wDataReg;
                end else if (offset == periphPkg::PWM_CTRL) begin
                    pwmRegs[offset] <= ahbApbPkg::dataT'(wDataReg[0]);
                end
            end
            pwmPrev   <= pwm_i;
            pwmEnPrev <= pwmEn;
            if (!pwmEn) begin
                seenRise <= 1'b0;
                if (!pwmEnPrev) begin
                    assert (!pwm_i) else begin
                        periphErrors++;
                        $display("ERROR pwm_o: got 0x%h expected 0x0", pwm_i);
                    end
                end
            end else if (pwm_i && !pwmPrev) begin
                if (seenRise) begin
                    assert (sinceRise == (pwmRegs[periphPkg::PWM_PERIOD] + 1) *
                                         (pwmRegs[periphPkg::PWM_PRE] + 1)) else begin
                        periphErrors++;
                        $display("ERROR pwm_o period: got 0x%h expected 0x%h cycles",
                                 sinceRise,
                                 (pwmRegs[periphPkg::PWM_PERIOD] + 1) *
                                 (pwmRegs[periphPkg::PWM_PRE] + 1));
                    end
                end
                seenRise  <= 1'b1;
                sinceRise <= 1;
            end else begin
                if (seenRise && !pwm_i && pwmPrev) begin
                    assert (sinceRise == pwmRegs[periphPkg::PWM_DUTY] *
                                         (pwmRegs[periphPkg::PWM_PRE] + 1)) else begin
                        periphErrors++;
                        $display("ERROR pwm_o high time: got 0x%h expected 0x%h cycles",
                                 sinceRise,
                                 pwmRegs[periphPkg::PWM_DUTY] *
                                 (pwmRegs[periphPkg::PWM_PRE] + 1));
                    end
                end
                sinceRise <= sinceRise + 1;
            end
            if (accept) begin
                addrReg  <= hAddr_i;
                writeReg <= hWrite_i;
                phase    <= 1;
            end else if (phase == 3) begin
                phase <= 0;
            end else if (phase != 0) begin
                phase <= phase + 1;
            end
        end
    end

endmodule

// ==== verification/tbApbSubsystem.sv ====
module tbApbSubsystem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int SEED         = 80900;
    // Five cycles per transfer, longest timer window, six longest PWM periods
    localparam int TRANSFERS    = 70;
    localparam int TIMER_WINDOW = 7 * 4 + 4;
    localparam int PWM_WINDOW   = 6 * 8 * 3;
    localparam int TEST_CYCLES  = TRANSFERS * 5 + TIMER_WINDOW + PWM_WINDOW + 20;

    logic              HCLK;
    logic              HRESETn;
    ahbApbPkg::addrT   hAddr_i;
    ahbApbPkg::htransE hTrans_i;
    logic              hWrite_i;
    ahbApbPkg::dataT   hWData_i;
    logic              hSel_i;
    logic              hReady_i;
    ahbApbPkg::dataT   hRData_o;
    logic              hReadyOut_o;
    logic              pwm_o;
    logic              timerIrq_o;
    int                dataErrors;
    int                timingErrors;
    int                periphErrors;
    ahbApbPkg::addrT   rbAddr [5];
    int unsigned       pre;
    int unsigned       cmp;
    int unsigned       period;
    int unsigned       duty;

    apbSubsystem dut (.*);

    apbSubsystemChecker portChecker (
        .HCLK           (HCLK),
        .HRESETn        (HRESETn),
        .hAddr_i        (hAddr_i),
        .hTrans_i       (hTrans_i),
        .hWrite_i       (hWrite_i),
        .hWData_i       (hWData_i),
        .hSel_i         (hSel_i),
        .hReady_i       (hReady_i),
        .hRData_i       (hRData_o),
        .hReadyOut_i    (hReadyOut_o),
        .pwm_i          (pwm_o),
        .timerIrq_i     (timerIrq_o),
        .dataErrors_o   (dataErrors),
        .timingErrors_o (timingErrors),
        .periphErrors_o (periphErrors)
    );

    initial begin
        HCLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) HCLK = ~HCLK;
        end
    end

    function automatic ahbApbPkg::addrT regAddr(input int slot, input int offset);
        return ahbApbPkg::addrT'((slot << ahbApbPkg::SLOT_LSB) |
                                 (offset << ahbApbPkg::OFFSET_LSB));
    endfunction

    // Address phase, then data phase until the bridge is ready again
    task automatic ahbTransfer(input ahbApbPkg::addrT addr, input logic write,
                               input ahbApbPkg::dataT wData);
        @(posedge HCLK);
        hAddr_i  <= addr;
        hWrite_i <= write;
        hTrans_i <= ahbApbPkg::HTRANS_NONSEQ;
        @(posedge HCLK);
        hTrans_i <= ahbApbPkg::HTRANS_IDLE;
        hWData_i <= wData;
        do begin
            @(posedge HCLK);
        end while (!hReadyOut_o);
    endtask

    task automatic ahbWrite(input ahbApbPkg::addrT addr, input ahbApbPkg::dataT wData);
        ahbTransfer(addr, 1'b1, wData);
    endtask

    task automatic ahbRead(input ahbApbPkg::addrT addr);
        ahbTransfer(addr, 1'b0, '0);
    endtask

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TEST_CYCLES * 2);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        HRESETn  = 1'b0;
        hAddr_i  = '0;
        hTrans_i = ahbApbPkg::HTRANS_IDLE;
        hWrite_i = 1'b0;
        hWData_i = '0;
        hSel_i   = 1'b0;
        hReady_i = 1'b1;
        rbAddr   = '{regAddr(ahbApbPkg::TIMER_SLOT, periphPkg::TIMER_PRE),
                     regAddr(ahbApbPkg::TIMER_SLOT, periphPkg::TIMER_CMP),
                     regAddr(ahbApbPkg::PWM_SLOT, periphPkg::PWM_PRE),
                     regAddr(ahbApbPkg::PWM_SLOT, periphPkg::PWM_PERIOD),
                     regAddr(ahbApbPkg::PWM_SLOT, periphPkg::PWM_DUTY)};
        repeat (2) @(posedge HCLK);
        HRESETn <= 1'b1;
        hSel_i  <= 1'b1;
        // Idle and busy cycles on a selected bus
        repeat (3) @(posedge HCLK);
        hTrans_i <= ahbApbPkg::HTRANS_BUSY;
        repeat (3) @(posedge HCLK);
        hTrans_i <= ahbApbPkg::HTRANS_IDLE;

        repeat (3) begin
            foreach (rbAddr[i]) begin
                ahbWrite(rbAddr[i], $urandom());
            end
            foreach (rbAddr[i]) begin
                ahbRead(rbAddr[i]);
            end
        end

        for (int slot = 2; slot < 16; slot++) begin
            ahbRead(regAddr(slot, $urandom_range(7)));
        end

        pre = $urandom_range(3);
        cmp = $urandom_range(6, 1);
        ahbWrite(regAddr(ahbApbPkg::TIMER_SLOT, periphPkg::TIMER_PRE), pre);
        ahbWrite(regAddr(ahbApbPkg::TIMER_SLOT, periphPkg::TIMER_CMP), cmp);
        ahbWrite(regAddr(ahbApbPkg::TIMER_SLOT, periphPkg::TIMER_CTRL), 32'd1);
        while (!timerIrq_o) begin
            ahbRead(regAddr(ahbApbPkg::TIMER_SLOT, periphPkg::TIMER_TMR));
        end
        ahbWrite(regAddr(ahbApbPkg::TIMER_SLOT, periphPkg::TIMER_CTRL), 32'd0);
        ahbWrite(regAddr(ahbApbPkg::TIMER_SLOT, periphPkg::TIMER_STATUS), 32'd1);

        pre    = $urandom_range(2);
        period = $urandom_range(7, 3);
        duty   = $urandom_range(period, 1);
        ahbWrite(regAddr(ahbApbPkg::PWM_SLOT, periphPkg::PWM_PRE), pre);
        ahbWrite(regAddr(ahbApbPkg::PWM_SLOT, periphPkg::PWM_PERIOD), period);
        ahbWrite(regAddr(ahbApbPkg::PWM_SLOT, periphPkg::PWM_DUTY), duty);
        ahbWrite(regAddr(ahbApbPkg::PWM_SLOT, periphPkg::PWM_CTRL), 32'd1);
        repeat (4) @(posedge pwm_o);
        ahbWrite(regAddr(ahbApbPkg::PWM_SLOT, periphPkg::PWM_CTRL), 32'd0);
        repeat (2 * (period + 1) * (pre + 1)) @(posedge HCLK);

        repeat (4) @(posedge HCLK);
        $display("Error counts: data %0d, timing %0d, peripheral %0d",
                 dataErrors, timingErrors, periphErrors);
        if ((dataErrors + timingErrors + periphErrors) == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
